// ==== design/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_XLEN     32
`define CORE_REG_AW   5
`define CORE_RESET_PC 32'h0000_0000

// RV32I major opcodes, instruction bits [6:0].
`define CORE_OP_OP     7'b0110011
`define CORE_OP_OP_IMM 7'b0010011
`define CORE_OP_LUI    7'b0110111
`define CORE_OP_AUIPC  7'b0010111
`define CORE_OP_BRANCH 7'b1100011
`define CORE_OP_JAL    7'b1101111
`define CORE_OP_JALR   7'b1100111
`define CORE_OP_SYSTEM 7'b1110011

`endif

// ==== design/core_pkg.sv ====
package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL,
        BR_JALR
    } branch_kind_t;

endpackage

// ==== design/core_fetch.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module core_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  next_inst,
    input  logic [`CORE_XLEN-1:0] next_pc,
    input  logic                  halted,
    output logic                  ibus_cyc,
    output logic                  ibus_stb,
    output logic [`CORE_XLEN-1:0] ibus_adr,
    input  logic                  ibus_ack,
    input  logic [`CORE_XLEN-1:0] ibus_dat_r,
    output logic                  inst_valid,
    output logic [`CORE_XLEN-1:0] inst,
    output logic [`CORE_XLEN-1:0] inst_pc,
    input  logic                  dec_ready
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_HOLD
    } state_t;

    state_t                state;
    logic [`CORE_XLEN-1:0] pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_BUS; // The first read goes out as soon as reset drops.
            pc    <= `CORE_RESET_PC;
        end else begin
            case (state)
                S_IDLE: begin
                    if (next_inst && !halted) begin
                        pc    <= next_pc;
                        state <= S_BUS;
                    end
                end
                S_BUS: begin
                    if (ibus_ack) begin
                        state <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (dec_ready) begin
                        state <= S_IDLE; // Wait in idle for execute to resolve the next pc.
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_BUS && ibus_ack) begin
            inst <= ibus_dat_r;
        end
    end

    assign ibus_cyc   = (state == S_BUS) && !rst;
    assign ibus_stb   = (state == S_BUS) && !rst;
    assign ibus_adr   = pc;
    assign inst_valid = (state == S_HOLD);
    assign inst_pc    = pc;

endmodule

// ==== design/core_decode.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module core_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_valid,
    input  logic [`CORE_XLEN-1:0]    inst,
    input  logic [`CORE_XLEN-1:0]    inst_pc,
    output logic                     dec_ready,
    output logic [`CORE_REG_AW-1:0]  rs1_addr,
    output logic [`CORE_REG_AW-1:0]  rs2_addr,
    input  logic [`CORE_XLEN-1:0]    rs1_data,
    input  logic [`CORE_XLEN-1:0]    rs2_data,
    output logic                     dec_valid,
    output core_pkg::alu_op_t        alu_op,
    output logic [`CORE_XLEN-1:0]    alu_a,
    output logic [`CORE_XLEN-1:0]    alu_b,
    output core_pkg::branch_kind_t   branch_kind,
    output logic [`CORE_XLEN-1:0]    br_rs1,
    output logic [`CORE_XLEN-1:0]    br_rs2,
    output logic [`CORE_XLEN-1:0]    br_target,
    output logic [`CORE_XLEN-1:0]    dec_pc,
    output logic [`CORE_REG_AW-1:0]  rd,
    output logic                     rd_wen,
    output logic                     is_ebreak,
    output logic                     is_illegal,
    input  logic                     exe_ready
);
    import core_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_j;
    alu_op_t               d_alu_op;
    logic [`CORE_XLEN-1:0] d_alu_a;
    logic [`CORE_XLEN-1:0] d_alu_b;
    branch_kind_t          d_kind;
    logic [`CORE_XLEN-1:0] d_target;
    logic                  d_wen;
    logic                  d_ebreak;
    logic                  d_illegal;
    logic                  take;

    function automatic alu_op_t funct3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    funct3_op = alt ? ALU_SUB : ALU_ADD;
            3'd1:    funct3_op = ALU_SLL;
            3'd2:    funct3_op = ALU_SLT;
            3'd3:    funct3_op = ALU_SLTU;
            3'd4:    funct3_op = ALU_XOR;
            3'd5:    funct3_op = alt ? ALU_SRA : ALU_SRL;
            3'd6:    funct3_op = ALU_OR;
            default: funct3_op = ALU_AND;
        endcase
    endfunction

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        d_alu_op  = ALU_ADD;
        d_alu_a   = rs1_data;
        d_alu_b   = rs2_data;
        d_kind    = BR_NONE;
        d_target  = inst_pc + imm_b;
        d_wen     = 1'b0;
        d_ebreak  = 1'b0;
        d_illegal = 1'b0;
        case (opcode)
            `CORE_OP_OP: begin
                d_alu_op = funct3_op(funct3, funct7[5]);
                d_wen    = 1'b1;
                // Only sub and sra use the alternate funct7.
                if (funct7 != 7'b0 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'd0 || funct3 == 3'd5))) begin
                    d_illegal = 1'b1;
                end
            end
            `CORE_OP_OP_IMM: begin
                d_alu_op = funct3_op(funct3, funct3 == 3'd5 && funct7[5]);
                d_alu_b  = imm_i;
                d_wen    = 1'b1;
                if ((funct3 == 3'd1 && funct7 != 7'b0) ||
                    (funct3 == 3'd5 && funct7 != 7'b0 && funct7 != 7'b0100000)) begin
                    d_illegal = 1'b1;
                end
            end
            `CORE_OP_LUI: begin
                d_alu_a = '0;
                d_alu_b = imm_u;
                d_wen   = 1'b1;
            end
            `CORE_OP_AUIPC: begin
                d_alu_a = inst_pc;
                d_alu_b = imm_u;
                d_wen   = 1'b1;
            end
            `CORE_OP_BRANCH: begin
                case (funct3)
                    3'd0:    d_kind = BR_BEQ;
                    3'd1:    d_kind = BR_BNE;
                    default: d_illegal = 1'b1;
                endcase
            end
            `CORE_OP_JAL: begin
                d_kind   = BR_JAL;
                d_target = inst_pc + imm_j;
                d_wen    = 1'b1;
            end
            `CORE_OP_JALR: begin
                d_kind    = BR_JALR;
                d_target  = (rs1_data + imm_i) & ~`CORE_XLEN'(1);
                d_wen     = 1'b1;
                d_illegal = (funct3 != 3'd0);
            end
            `CORE_OP_SYSTEM: begin
                if (inst == 32'h0010_0073) begin
                    d_ebreak = 1'b1;
                end else begin
                    d_illegal = 1'b1;
                end
            end
            default: d_illegal = 1'b1;
        endcase
        if (d_ebreak || d_illegal) begin
            d_wen = 1'b0; // A halting instruction never writes back.
        end
    end

    assign dec_ready = !dec_valid;
    assign take      = inst_valid && dec_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (take) begin
            dec_valid <= 1'b1;
        end else if (exe_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            alu_op      <= d_alu_op;
            alu_a       <= d_alu_a;
            alu_b       <= d_alu_b;
            branch_kind <= d_kind;
            br_rs1      <= rs1_data;
            br_rs2      <= rs2_data;
            br_target   <= d_target;
            dec_pc      <= inst_pc;
            rd          <= inst[11:7];
            rd_wen      <= d_wen;
            is_ebreak   <= d_ebreak;
            is_illegal  <= d_illegal;
        end
    end

endmodule

// ==== design/core_regfile.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module core_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`CORE_REG_AW-1:0] rs1_addr,
    input  logic [`CORE_REG_AW-1:0] rs2_addr,
    output logic [`CORE_XLEN-1:0]   rs1_data,
    output logic [`CORE_XLEN-1:0]   rs2_data,
    input  logic                    wb_wen,
    input  logic [`CORE_REG_AW-1:0] wb_addr,
    input  logic [`CORE_XLEN-1:0]   wb_data
);
    logic [`CORE_XLEN-1:0] regs [0:(1 << `CORE_REG_AW)-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `CORE_REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wen && wb_addr != '0) begin
            regs[wb_addr] <= wb_data; // x0 is never written.
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== design/core_execute.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module core_execute (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dec_valid,
    input  core_pkg::alu_op_t        alu_op,
    input  logic [`CORE_XLEN-1:0]    alu_a,
    input  logic [`CORE_XLEN-1:0]    alu_b,
    input  core_pkg::branch_kind_t   branch_kind,
    input  logic [`CORE_XLEN-1:0]    br_rs1,
    input  logic [`CORE_XLEN-1:0]    br_rs2,
    input  logic [`CORE_XLEN-1:0]    br_target,
    input  logic [`CORE_XLEN-1:0]    dec_pc,
    input  logic [`CORE_REG_AW-1:0]  rd,
    input  logic                     rd_wen,
    input  logic                     is_ebreak,
    input  logic                     is_illegal,
    output logic                     exe_ready,
    output logic                     wb_wen,
    output logic [`CORE_REG_AW-1:0]  wb_addr,
    output logic [`CORE_XLEN-1:0]    wb_data,
    output logic                     next_inst,
    output logic [`CORE_XLEN-1:0]    next_pc,
    output logic                     retire_valid,
    output logic                     retire_rd_wen,
    output logic [`CORE_XLEN-1:0]    retire_pc,
    output logic [`CORE_XLEN-1:0]    retire_rd_wdata,
    output logic [`CORE_REG_AW-1:0]  retire_rd,
    output logic                     halted,
    output logic                     illegal
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] alu_out;
    logic [`CORE_XLEN-1:0] pc_plus4;
    logic                  is_jump;
    logic                  redirect;
    logic                  accept;

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_out = alu_a - alu_b;
            ALU_AND:  alu_out = alu_a & alu_b;
            ALU_OR:   alu_out = alu_a | alu_b;
            ALU_XOR:  alu_out = alu_a ^ alu_b;
            ALU_SLL:  alu_out = alu_a << alu_b[4:0];
            ALU_SRL:  alu_out = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_out = $signed(alu_a) >>> alu_b[4:0];
            ALU_SLT:  alu_out = {{(`CORE_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_out = {{(`CORE_XLEN-1){1'b0}}, alu_a < alu_b};
            default:  alu_out = alu_a + alu_b;
        endcase
    end

    assign pc_plus4 = dec_pc + `CORE_XLEN'(4);
    assign is_jump  = (branch_kind == BR_JAL) || (branch_kind == BR_JALR);
    assign redirect = is_jump ||
                      (branch_kind == BR_BEQ && br_rs1 == br_rs2) ||
                      (branch_kind == BR_BNE && br_rs1 != br_rs2);

    assign exe_ready = !halted;
    assign accept    = dec_valid && exe_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            wb_wen       <= 1'b0;
            halted       <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire_valid <= accept;
            wb_wen       <= accept && rd_wen;
            if (accept && (is_ebreak || is_illegal)) begin
                halted  <= 1'b1; // Held until the next reset.
                illegal <= is_illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_addr   <= rd;
            wb_data   <= is_jump ? pc_plus4 : alu_out; // Jumps link pc+4.
            next_pc   <= redirect ? br_target : pc_plus4;
            retire_pc <= dec_pc;
        end
    end

    assign next_inst       = retire_valid;
    assign retire_rd_wen   = wb_wen;
    assign retire_rd       = wb_addr;
    assign retire_rd_wdata = wb_data;

endmodule

// ==== design/core_top.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module core_top (
    input  logic                    clk,
    input  logic                    rst,
    output logic                    ibus_cyc,
    output logic                    ibus_stb,
    output logic [`CORE_XLEN-1:0]   ibus_adr,
    input  logic                    ibus_ack,
    input  logic [`CORE_XLEN-1:0]   ibus_dat_r,
    output logic                    retire_valid,
    output logic [`CORE_XLEN-1:0]   retire_pc,
    output logic                    retire_rd_wen,
    output logic [`CORE_REG_AW-1:0] retire_rd,
    output logic [`CORE_XLEN-1:0]   retire_rd_wdata,
    output logic                    halted,
    output logic                    illegal
);
    import core_pkg::*;

    logic                    inst_valid;
    logic [`CORE_XLEN-1:0]   inst;
    logic [`CORE_XLEN-1:0]   inst_pc;
    logic                    dec_ready;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic                    dec_valid;
    alu_op_t                 alu_op;
    logic [`CORE_XLEN-1:0]   alu_a;
    logic [`CORE_XLEN-1:0]   alu_b;
    branch_kind_t            branch_kind;
    logic [`CORE_XLEN-1:0]   br_rs1;
    logic [`CORE_XLEN-1:0]   br_rs2;
    logic [`CORE_XLEN-1:0]   br_target;
    logic [`CORE_XLEN-1:0]   dec_pc;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    rd_wen;
    logic                    is_ebreak;
    logic                    is_illegal;
    logic                    exe_ready;
    logic                    wb_wen;
    logic [`CORE_REG_AW-1:0] wb_addr;
    logic [`CORE_XLEN-1:0]   wb_data;
    logic                    next_inst;
    logic [`CORE_XLEN-1:0]   next_pc;

    core_fetch i_fetch (
        .clk        (clk),
        .rst        (rst),
        .next_inst  (next_inst),
        .next_pc    (next_pc),
        .halted     (halted),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_ack   (ibus_ack),
        .ibus_dat_r (ibus_dat_r),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .dec_ready  (dec_ready)
    );

    core_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .dec_ready   (dec_ready),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dec_valid   (dec_valid),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .branch_kind (branch_kind),
        .br_rs1      (br_rs1),
        .br_rs2      (br_rs2),
        .br_target   (br_target),
        .dec_pc      (dec_pc),
        .rd          (rd),
        .rd_wen      (rd_wen),
        .is_ebreak   (is_ebreak),
        .is_illegal  (is_illegal),
        .exe_ready   (exe_ready)
    );

    core_regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_wen   (wb_wen),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    core_execute i_execute (
        .clk             (clk),
        .rst             (rst),
        .dec_valid       (dec_valid),
        .alu_op          (alu_op),
        .alu_a           (alu_a),
        .alu_b           (alu_b),
        .branch_kind     (branch_kind),
        .br_rs1          (br_rs1),
        .br_rs2          (br_rs2),
        .br_target       (br_target),
        .dec_pc          (dec_pc),
        .rd              (rd),
        .rd_wen          (rd_wen),
        .is_ebreak       (is_ebreak),
        .is_illegal      (is_illegal),
        .exe_ready       (exe_ready),
        .wb_wen          (wb_wen),
        .wb_addr         (wb_addr),
        .wb_data         (wb_data),
        .next_inst       (next_inst),
        .next_pc         (next_pc),
        .retire_valid    (retire_valid),
        .retire_rd_wen   (retire_rd_wen),
        .retire_pc       (retire_pc),
        .retire_rd_wdata (retire_rd_wdata),
        .retire_rd       (retire_rd),
        .halted          (halted),
        .illegal         (illegal)
    );

endmodule

// ==== dv/inst_mem_model.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module inst_mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wait_en,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic [`CORE_XLEN-1:0] adr,
    output logic                  ack,
    output logic [`CORE_XLEN-1:0] dat_r,
    output int                    proto_errors
);
    logic [`CORE_XLEN-1:0] mem [0:255];
    logic [`CORE_XLEN-1:0] req_adr;
    logic                  busy;
    logic [1:0]            wait_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack          <= 1'b0;
            busy         <= 1'b0;
            wait_cnt     <= '0;
            proto_errors <= 0;
        end else begin
            ack <= 1'b0;
            if (!busy && cyc && stb && !ack) begin
                busy     <= 1'b1;
                req_adr  <= adr;
                wait_cnt <= wait_en ? 2'($urandom % 4) : 2'd0; // 0 to 3 extra cycles.
            end else if (busy) begin
                // A classic master must hold its request until ack.
                if (!(cyc && stb) || adr != req_adr) begin
                    $display("Bus request dropped or changed before ack at %h", req_adr);
                    proto_errors <= proto_errors + 1;
                end
                if (wait_cnt == 2'd0) begin
                    ack   <= 1'b1;
                    dat_r <= mem[req_adr[9:2]];
                    busy  <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

// ==== dv/core_tb.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module core_tb;
    logic        clk;
    logic        rst;
    logic        wait_en;
    logic        ibus_cyc;
    logic        ibus_stb;
    logic [31:0] ibus_adr;
    logic        ibus_ack;
    logic [31:0] ibus_dat_r;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_rd_wen;
    logic [4:0]  retire_rd;
    logic [31:0] retire_rd_wdata;
    logic        halted;
    logic        illegal;
    int          proto_errors;
    int          errors;
    int          failures;
    int          widx;
    logic [31:0] mregs [0:31];
    logic [31:0] mpc;
    logic [31:0] trace [$];
    logic [31:0] ref_trace [$];

    core_top i_dut (
        .clk (clk), .rst (rst),
        .ibus_cyc (ibus_cyc), .ibus_stb (ibus_stb), .ibus_adr (ibus_adr),
        .ibus_ack (ibus_ack), .ibus_dat_r (ibus_dat_r),
        .retire_valid (retire_valid), .retire_pc (retire_pc),
        .retire_rd_wen (retire_rd_wen), .retire_rd (retire_rd),
        .retire_rd_wdata (retire_rd_wdata), .halted (halted), .illegal (illegal)
    );

    inst_mem_model i_mem (
        .clk (clk), .rst (rst), .wait_en (wait_en), .cyc (ibus_cyc), .stb (ibus_stb),
        .adr (ibus_adr), .ack (ibus_ack), .dat_r (ibus_dat_r),
        .proto_errors (proto_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[4:0]; // Arithmetic shift keeps the sign.
                else r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic clear_mem();
        for (int i = 0; i < 256; i++) begin
            i_mem.mem[i] = 32'hbad0_0000 | (i << 2); // Low bits 00 never decode.
        end
        widx = 0;
    endtask

    task automatic put(logic [31:0] word);
        i_mem.mem[widx] = word;
        widx++;
    endtask

    task automatic check_val(string test, string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test, what, exp, act);
            errors++;
        end
    endtask

    // ISA reference step on the instruction at mpc.
    task automatic model_step(output logic wen, output logic [4:0] rd,
                              output logic [31:0] val, output logic stop, output logic bad);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] npc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        w = i_mem.mem[mpc[9:2]];
        rd = w[11:7];
        f3 = w[14:12];
        f7 = w[31:25];
        a = mregs[w[19:15]];
        b = mregs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        npc = mpc + 32'd4;
        wen = 1'b0;
        val = '0;
        stop = 1'b0;
        bad = 1'b0;
        case (w[6:0])
            7'h13: begin
                wen = 1'b1;
                val = alu(f3, f3 == 3'd5 && f7[5], a, imm_i);
                bad = (f3 == 3'd1 && f7 != 0) || (f3 == 3'd5 && f7 != 0 && f7 != 7'h20);
            end
            7'h33: begin
                wen = 1'b1;
                val = alu(f3, f7[5], a, b);
                bad = f7 != 0 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end
            7'h37: begin
                wen = 1'b1;
                val = {w[31:12], 12'b0};
            end
            7'h17: begin
                wen = 1'b1;
                val = mpc + {w[31:12], 12'b0};
            end
            7'h63: begin
                if (f3 > 3'd1) bad = 1'b1;
                else if ((a == b) == (f3 == 3'd0))
                    npc = mpc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            7'h6f: begin
                wen = 1'b1;
                val = mpc + 32'd4;
                npc = mpc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                wen = 1'b1;
                val = mpc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
                bad = f3 != 3'd0;
            end
            7'h73: begin
                if (w == 32'h0010_0073) stop = 1'b1;
                else bad = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        if (bad || stop) begin
            wen = 1'b0;
            stop = 1'b1;
        end
        if (wen && rd != 0) mregs[rd] = val;
        mpc = npc;
    endtask

    task automatic run_prog(string name, logic wt);
        int          cnt;
        logic        wen;
        logic [4:0]  rd;
        logic [31:0] val;
        logic        stop;
        logic        bad;
        @(posedge clk);
        rst <= 1'b1;
        wait_en <= wt;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        mpc = `CORE_RESET_PC;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        trace.delete();
        cnt = 0;
        while (!ibus_ack) begin
            @(negedge clk);
            if (retire_valid) begin
                $display("%s: a retire came before the first bus ack", name);
                failures++;
            end
            if (ibus_stb) check_val(name, "first fetch address", `CORE_RESET_PC, ibus_adr);
            cnt++;
            if (cnt > 50) begin
                $display("%s: timed out waiting for the first bus ack", name);
                failures++;
                return;
            end
        end
        stop = 1'b0;
        bad = 1'b0;
        while (!stop) begin
            cnt = 0;
            do begin
                @(negedge clk);
                cnt++;
            end while (!retire_valid && cnt < 100);
            if (!retire_valid) begin
                $display("%s: timed out waiting for a retire at pc %h", name, mpc);
                failures++;
                return;
            end
            check_val(name, "retire pc", mpc, retire_pc);
            model_step(wen, rd, val, stop, bad);
            check_val(name, "retire write enable", 32'(wen), 32'(retire_rd_wen));
            if (wen) begin
                check_val(name, "retire rd", 32'(rd), 32'(retire_rd));
                check_val(name, "retire value", val, retire_rd_wdata);
            end
            trace.push_back(retire_pc);
            trace.push_back(wen ? retire_rd_wdata : 32'd0);
        end
        check_val(name, "halted", 32'd1, 32'(halted));
        check_val(name, "illegal", 32'(bad), 32'(illegal));
        repeat (20) begin
            @(negedge clk);
            if (ibus_cyc || ibus_stb || retire_valid) begin
                $display("%s: bus or retire activity after the core halted", name);
                failures++;
            end
        end
        failures += proto_errors; // The memory model clears its count on the next reset.
    endtask

    task automatic test_reset();
        clear_mem();
        put(32'h0010_0073);
        run_prog("reset", 1'b0);
    endtask

    task automatic test_alu();
        clear_mem();
        put(enc_i(-5, 0, 0, 1, 7'h13));
        put(enc_i(100, 0, 0, 2, 7'h13));
        put(enc_r(0, 2, 1, 0, 3));
        put(enc_r(32, 2, 1, 0, 4));
        put(enc_r(0, 2, 1, 7, 5));
        put(enc_r(0, 2, 1, 6, 6));
        put(enc_r(0, 2, 1, 4, 7));
        put(enc_r(0, 1, 2, 1, 8));
        put(enc_i(3, 2, 1, 9, 7'h13));
        put(enc_i(4, 1, 5, 10, 7'h13));
        put(enc_i(1024 + 2, 1, 5, 11, 7'h13));
        put(enc_r(32, 2, 1, 5, 12));
        put(enc_r(0, 2, 1, 5, 21));
        put(enc_r(0, 2, 1, 2, 13));
        put(enc_r(0, 2, 1, 3, 14));
        put(enc_i(-4, 1, 2, 15, 7'h13));
        put(enc_i(-1, 2, 3, 16, 7'h13));
        put(enc_i(-1, 1, 4, 17, 7'h13));
        put(enc_i(-256, 2, 6, 22, 7'h13));
        put(enc_i(-16, 1, 7, 23, 7'h13));
        put(enc_i(7, 2, 0, 0, 7'h13));
        put({20'habcde, 5'd18, 7'h37});
        put({20'h12345, 5'd19, 7'h17});
        put(enc_r(0, 0, 0, 0, 20));
        put(32'h0010_0073);
        run_prog("alu", 1'b0);
    endtask

    task automatic test_control();
        clear_mem();
        put(enc_i(5, 0, 0, 1, 7'h13));
        put(enc_i(5, 0, 0, 2, 7'h13));
        put(enc_b(8, 2, 1, 0));
        put(enc_i(1, 0, 0, 3, 7'h13));
        put(enc_b(8, 2, 1, 1));
        put(enc_i(2, 0, 0, 4, 7'h13));
        put(enc_b(8, 0, 1, 0));
        put(enc_j(12, 5));
        put(enc_i(6, 0, 0, 6, 7'h13));
        put(enc_i(7, 0, 0, 7, 7'h13));
        put(enc_i(17, 5, 0, 8, 7'h67));
        put(enc_i(9, 0, 0, 9, 7'h13));
        put(enc_b(8, 0, 1, 1));
        put(enc_i(10, 0, 0, 10, 7'h13));
        put(32'h0010_0073);
        run_prog("control", 1'b0);
    endtask

    task automatic test_wait_states();
        clear_mem();
        put(enc_i(12, 0, 0, 1, 7'h13));
        put(enc_i(3, 2, 0, 2, 7'h13));
        put(enc_r(0, 2, 3, 4, 3));
        put(enc_i(2, 2, 1, 4, 7'h13));
        put(enc_i(-1, 1, 0, 1, 7'h13));
        put(enc_b(-16, 0, 1, 1));
        put(32'h0010_0073);
        run_prog("no_wait", 1'b0);
        ref_trace = trace;
        run_prog("wait_states", 1'b1);
        check_val("wait_states", "trace length", ref_trace.size(), trace.size());
        for (int i = 0; i < ref_trace.size() && i < trace.size(); i++) begin
            check_val("wait_states", "trace entry", ref_trace[i], trace[i]);
        end
    endtask

    task automatic test_illegal();
        clear_mem();
        put(enc_i(7, 0, 0, 1, 7'h13));
        put(32'h0000_008b); // Custom opcode that targets x1.
        run_prog("illegal", 1'b1);
    endtask

    initial begin
        rst = 1'b1;
        wait_en = 1'b0;
        errors = 0;
        failures = 0;
        void'($urandom(32'h9766));
        test_reset();
        test_alu();
        test_control();
        test_wait_states();
        test_illegal();
        $display("Done with %0d mismatches and %0d other errors", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/core_pkg.sv
design/core_fetch.sv
design/core_decode.sv
design/core_regfile.sv
design/core_execute.sv
design/core_top.sv
dv/inst_mem_model.sv
dv/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= core_tb
RTL_TOP   ?= core_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
